// File: rtl/obj_pkg.sv
// **************************************************************************
// Object table geometry and shared enums
// One page holds OBJ_MAX entries of four 16-bit words each
// Two pages live in every byte RAM, selected by the top address bit
// END_MARK in the upper attribute byte ends a table early
// **************************************************************************
`default_nettype none

package obj_pkg;

    // Entry index width within one page
    localparam int OBJ_IDX_W = 10;

    // Entries per page
    localparam int OBJ_MAX = 1 << OBJ_IDX_W;

    // Byte RAM address: page bit, half bit, entry index
    localparam int RAM_AW = OBJ_IDX_W + 2;

    // Upper attribute byte that terminates the table
    localparam logic [7:0] END_MARK = 8'hFF;

    // Scanner FSM
    // IDLE doubles as the first low-half request
    typedef enum logic [1:0] {
        IDLE,
        RD_LO,
        RD_HI,
        EMIT
    } scan_state_t;

    // Decoded CPU access
    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_READ
    } cpu_op_t;

endpackage

`default_nettype wire

// File: rtl/obj_dual_ram.sv
// **************************************************************************
// Byte-wide dual-port RAM, single clock
// Port 0 writes and reads, port 1 only reads
// Both outputs registered, one cycle of read latency
// Read during write on port 0 returns the old byte
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_dual_ram (
    input  wire                        clk_cpu,
    input  wire                        we,
    input  wire  [obj_pkg::RAM_AW-1:0] addr0,
    input  wire  [7:0]                 data0,
    input  wire  [obj_pkg::RAM_AW-1:0] addr1,
    output logic [7:0]                 q0,
    output logic [7:0]                 q1
);
    import obj_pkg::*;

    // Both pages, both halves
    logic [7:0] mem [0:(1 << RAM_AW)-1];

    always_ff @(posedge clk_cpu) begin
        if (we) begin
            mem[addr0] <= data0;
        end
        // CPU side read back
        q0 <= mem[addr0];
        // Scanner side
        q1 <= mem[addr1];
    end

endmodule

`default_nettype wire

// File: rtl/obj_cpu_port.sv
// **************************************************************************
// CPU access to the object table, 16-bit words with active-low byte strobes
// cs must be a single-cycle strobe, next one only after ok
// Writes acknowledge one cycle after cs, reads two cycles after
// addr[13] flips the page relative to obank
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_cpu_port (
    input  wire                        clk_cpu,
    input  wire                        arst_n,
    input  wire                        cs,
    input  wire                        rnw,
    input  wire  [1:0]                 dsn,
    input  wire  [13:1]                addr,
    input  wire  [15:0]                din,
    input  wire                        obank,
    output logic                       ok,
    output logic [15:0]                dout,
    output logic [obj_pkg::RAM_AW-1:0] wr_addr,
    output logic [15:0]                wdata,
    output logic [1:0]                 we_xy,
    output logic [1:0]                 we_at,
    input  wire  [15:0]                q_xy,
    input  wire  [15:0]                q_at
);
    import obj_pkg::*;

    cpu_op_t op;
    logic    is_wr;
    logic    rd_pend;
    logic    rd_half;

    // Access kind from strobe and direction
    always_comb begin
        if (!cs) begin
            op = OP_NONE;
        end else if (rnw) begin
            op = OP_READ;
        end else begin
            op = OP_WRITE;
        end
    end

    assign is_wr = (op == OP_WRITE);

    // Page, then half (X/code vs Y/attr), then entry index
    assign wr_addr = {obank ^ addr[13], addr[1], addr[12:3]};
    assign wdata   = din;

    // addr[2] low selects the X/Y pair, high the code/attr pair
    assign we_xy = {2{is_wr & ~addr[2]}} & ~dsn;
    assign we_at = {2{is_wr &  addr[2]}} & ~dsn;

    // Ack timing
    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            ok      <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= (op == OP_READ);
            // Write done at the cs edge, read waits for RAM data
            ok      <= is_wr | rd_pend;
        end
    end

    // Read data path
    always_ff @(posedge clk_cpu) begin
        if (op == OP_READ) begin
            rd_half <= addr[2];
        end
        if (rd_pend) begin
            dout <= rd_half ? q_at : q_xy;
        end
    end

endmodule

`default_nettype wire

// File: rtl/obj_ram.sv
// **************************************************************************
// Double-paged object RAM from four byte lanes
// X/Y pair and code/attr pair, each split low and high byte
// Half 0 of a pair holds X or code, half 1 holds Y or attr
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_ram (
    input  wire                        clk_cpu,
    input  wire  [obj_pkg::RAM_AW-1:0] wr_addr,
    input  wire  [15:0]                wdata,
    input  wire  [1:0]                 we_xy,
    input  wire  [1:0]                 we_at,
    input  wire  [obj_pkg::RAM_AW-1:0] rd_addr,
    output wire  [15:0]                q_xy,
    output wire  [15:0]                q_at,
    output wire  [15:0]                obj_xy,
    output wire  [15:0]                obj_attr
);

    // X and Y, low byte
    obj_dual_ram xy_lo (
        .clk_cpu ( clk_cpu        ),
        .we      ( we_xy[0]       ),
        .addr0   ( wr_addr        ),
        .data0   ( wdata[7:0]     ),
        .addr1   ( rd_addr        ),
        .q0      ( q_xy[7:0]      ),
        .q1      ( obj_xy[7:0]    )
    );

    // X and Y, high byte
    obj_dual_ram xy_hi (
        .clk_cpu ( clk_cpu        ),
        .we      ( we_xy[1]       ),
        .addr0   ( wr_addr        ),
        .data0   ( wdata[15:8]    ),
        .addr1   ( rd_addr        ),
        .q0      ( q_xy[15:8]     ),
        .q1      ( obj_xy[15:8]   )
    );

    // Code and attr, low byte
    obj_dual_ram at_lo (
        .clk_cpu ( clk_cpu        ),
        .we      ( we_at[0]       ),
        .addr0   ( wr_addr        ),
        .data0   ( wdata[7:0]     ),
        .addr1   ( rd_addr        ),
        .q0      ( q_at[7:0]      ),
        .q1      ( obj_attr[7:0]  )
    );

    // Code and attr, high byte
    // Upper attr byte carries the end marker
    obj_dual_ram at_hi (
        .clk_cpu ( clk_cpu        ),
        .we      ( we_at[1]       ),
        .addr0   ( wr_addr        ),
        .data0   ( wdata[15:8]    ),
        .addr1   ( rd_addr        ),
        .q0      ( q_at[15:8]     ),
        .q1      ( obj_attr[15:8] )
    );

endmodule

`default_nettype wire

// File: rtl/obj_scanner.sv
// **************************************************************************
// Object table scanner, walks the page the CPU does not see
// One record every 3 cycles, first one 3 cycles after frame
// No back-pressure, spr_valid is a single-cycle pulse
// Frame pulses while busy are dropped, page latched at frame
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_scanner (
    input  wire                        clk_cpu,
    input  wire                        arst_n,
    input  wire                        frame,
    input  wire                        obank,
    input  wire  [15:0]                obj_xy,
    input  wire  [15:0]                obj_attr,
    output logic [obj_pkg::RAM_AW-1:0] rd_addr,
    output logic                       spr_valid,
    output logic [15:0]                spr_x,
    output logic [15:0]                spr_y,
    output logic [15:0]                spr_code,
    output logic [15:0]                spr_attr,
    output logic                       scan_done
);
    import obj_pkg::*;

    scan_state_t        state;
    // Extra top bit marks the walk past the last entry
    logic [OBJ_IDX_W:0] idx;
    logic               page;
    logic               page_sel;
    logic               marker;

    // IDLE already points at entry 0 low half of the hidden page
    assign page_sel = (state == IDLE) ? ~obank : page;
    assign rd_addr  = {page_sel, state == RD_HI, idx[OBJ_IDX_W-1:0]};
    assign marker   = (obj_attr[15:8] == END_MARK);

    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            idx       <= '0;
            page      <= 1'b0;
            spr_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            spr_valid <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                IDLE: if (frame) begin
                    page  <= ~obank;
                    state <= RD_HI;
                end
                // Table exhausted without a marker
                RD_LO: if (idx == (OBJ_IDX_W+1)'(OBJ_MAX)) begin
                    scan_done <= 1'b1;
                    idx       <= '0;
                    state     <= IDLE;
                end else begin
                    state <= RD_HI;
                end
                RD_HI: state <= EMIT;
                EMIT: if (marker) begin
                    scan_done <= 1'b1;
                    idx       <= '0;
                    state     <= IDLE;
                end else begin
                    spr_valid <= 1'b1;
                    idx       <= idx + 1'b1;
                    state     <= RD_LO;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Record fields, low half then high half
    always_ff @(posedge clk_cpu) begin
        if (state == RD_HI) begin
            spr_x    <= obj_xy;
            spr_code <= obj_attr;
        end
        if (state == EMIT) begin
            spr_y    <= obj_xy;
            spr_attr <= obj_attr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/obj_sys.sv
// **************************************************************************
// Object table subsystem top, single clock
// CPU port, double-paged RAM and scanner
// obank picks the visible page, scanner uses the other one
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_sys (
    input  wire         clk_cpu,
    input  wire         arst_n,
    input  wire         cs,
    input  wire         rnw,
    input  wire  [1:0]  dsn,
    input  wire  [13:1] addr,
    input  wire  [15:0] din,
    input  wire         obank,
    output wire         ok,
    output wire  [15:0] dout,
    input  wire         frame,
    output wire         spr_valid,
    output wire  [15:0] spr_x,
    output wire  [15:0] spr_y,
    output wire  [15:0] spr_code,
    output wire  [15:0] spr_attr,
    output wire         scan_done
);
    import obj_pkg::*;

    // CPU side RAM port
    wire [RAM_AW-1:0] wr_addr;
    wire [15:0]       wdata;
    wire [1:0]        we_xy;
    wire [1:0]        we_at;
    wire [15:0]       q_xy;
    wire [15:0]       q_at;

    // Scanner side RAM port
    wire [RAM_AW-1:0] rd_addr;
    wire [15:0]       obj_xy;
    wire [15:0]       obj_attr;

    obj_cpu_port u_port (
        .clk_cpu ( clk_cpu ), .arst_n ( arst_n ),
        .cs      ( cs      ), .rnw    ( rnw    ),
        .dsn     ( dsn     ), .addr   ( addr   ),
        .din     ( din     ), .obank  ( obank  ),
        .ok      ( ok      ), .dout   ( dout   ),
        .wr_addr ( wr_addr ), .wdata  ( wdata  ),
        .we_xy   ( we_xy   ), .we_at  ( we_at  ),
        .q_xy    ( q_xy    ), .q_at   ( q_at   )
    );

    obj_ram u_ram (
        .clk_cpu ( clk_cpu ), .wr_addr  ( wr_addr  ),
        .wdata   ( wdata   ), .we_xy    ( we_xy    ),
        .we_at   ( we_at   ), .rd_addr  ( rd_addr  ),
        .q_xy    ( q_xy    ), .q_at     ( q_at     ),
        .obj_xy  ( obj_xy  ), .obj_attr ( obj_attr )
    );

    obj_scanner u_scan (
        .clk_cpu   ( clk_cpu   ), .arst_n    ( arst_n    ),
        .frame     ( frame     ), .obank     ( obank     ),
        .obj_xy    ( obj_xy    ), .obj_attr  ( obj_attr  ),
        .rd_addr   ( rd_addr   ), .spr_valid ( spr_valid ),
        .spr_x     ( spr_x     ), .spr_y     ( spr_y     ),
        .spr_code  ( spr_code  ), .spr_attr  ( spr_attr  ),
        .scan_done ( scan_done )
    );

endmodule

`default_nettype wire

// File: bench/obj_sys_sva.sv
// **************************************************************************
// Bound checks on the CPU ack and the sprite strobes
// Assumes single-cycle cs with at most one access in flight
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_sys_sva (
    input wire clk_cpu,
    input wire arst_n,
    input wire cs,
    input wire rnw,
    input wire ok,
    input wire spr_valid,
    input wire scan_done
);

    // Write ack one cycle after cs
    a_wr_ok: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        (cs && !rnw) |=> ok)
        else $error("write ack missing one cycle after cs");

    // Read ack two cycles after cs
    a_rd_ok: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        $past(cs && rnw, 2) |-> ok)
        else $error("read ack missing two cycles after cs");

    // No ack without a matching access
    a_ok_src: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        ok |-> ($past(cs && !rnw) || $past(cs && rnw, 2)))
        else $error("ok raised without a matching access");

    a_excl: assert property (@(posedge clk_cpu) disable iff (!arst_n)
        !(spr_valid && scan_done))
        else $error("spr_valid and scan_done high together");

    // Strobes quiet while in reset
    a_rst_quiet: assert property (@(posedge clk_cpu)
        !arst_n |-> (!ok && !spr_valid && !scan_done))
        else $error("output strobe high during reset");

endmodule

bind obj_sys obj_sys_sva u_sva (
    .clk_cpu   ( clk_cpu   ),
    .arst_n    ( arst_n    ),
    .cs        ( cs        ),
    .rnw       ( rnw       ),
    .ok        ( ok        ),
    .spr_valid ( spr_valid ),
    .scan_done ( scan_done )
);

`default_nettype wire

// File: bench/obj_sys_tb.sv
// **************************************************************************
// Table-driven testbench for the object table subsystem
// OP_NONE rows load a random table into the hidden page and pulse frame
// For those rows data is the entry count and the marker index, and addr is
// the record count after which a second frame and an obank toggle go in
// **************************************************************************
`timescale 1ns/1ps
`default_nettype none

module obj_sys_tb;
    import obj_pkg::*;

    localparam int N_ROWS   = 21;
    localparam int N_FRAMES = 5;

    logic         clk_cpu = 1'b0;
    logic         arst_n;
    logic         cs;
    logic         rnw;
    logic [1:0]   dsn;
    logic [13:1]  addr;
    logic [15:0]  din;
    logic         obank;
    logic         frame;
    wire          ok;
    wire  [15:0]  dout;
    wire          spr_valid;
    wire  [15:0]  spr_x;
    wire  [15:0]  spr_y;
    wire  [15:0]  spr_code;
    wire  [15:0]  spr_attr;
    wire          scan_done;

    // Stimulus table
    string        row_name [N_ROWS];
    cpu_op_t      row_op   [N_ROWS];
    logic         row_bank [N_ROWS];
    logic [13:1]  row_addr [N_ROWS];
    logic [1:0]   row_dsn  [N_ROWS];
    logic [15:0]  row_data [N_ROWS];
    logic [15:0]  row_exp  [N_ROWS];

    // Reference pages indexed by page, entry and word
    logic [15:0]  model [2][OBJ_MAX][4];

    int n_checks;
    int n_mismatch;
    int n_other;
    int seed_ret;

    always #20 clk_cpu = ~clk_cpu;

    obj_sys u_obj_sys (
        .clk_cpu   ( clk_cpu   ), .arst_n    ( arst_n    ),
        .cs        ( cs        ), .rnw       ( rnw       ),
        .dsn       ( dsn       ), .addr      ( addr      ),
        .din       ( din       ), .obank     ( obank     ),
        .ok        ( ok        ), .dout      ( dout      ),
        .frame     ( frame     ), .spr_valid ( spr_valid ),
        .spr_x     ( spr_x     ), .spr_y     ( spr_y     ),
        .spr_code  ( spr_code  ), .spr_attr  ( spr_attr  ),
        .scan_done ( scan_done )
    );

    task automatic set_row(input int i, input string nm, input cpu_op_t op, input logic bk,
                           input logic [13:1] a, input logic [1:0] be_n,
                           input logic [15:0] d, input logic [15:0] e);
        row_name[i] = nm;
        row_op[i]   = op;
        row_bank[i] = bk;
        row_addr[i] = a;
        row_dsn[i]  = be_n;
        row_data[i] = d;
        row_exp[i]  = e;
    endtask

    task automatic build_table();
        // Word and byte accesses on both pages and with both banks
        set_row(0,  "wr_x_p0",       OP_WRITE, 1'b0, 13'h0014, 2'b00, 16'h1234, 16'h0000);
        set_row(1,  "rd_x_p0",       OP_READ,  1'b0, 13'h0014, 2'b00, 16'h0000, 16'h1234);
        set_row(2,  "wr_attr_p0",    OP_WRITE, 1'b0, 13'h0017, 2'b00, 16'hABCD, 16'h0000);
        set_row(3,  "rd_attr_p0",    OP_READ,  1'b0, 13'h0017, 2'b00, 16'h0000, 16'hABCD);
        set_row(4,  "wr_lo_byte",    OP_WRITE, 1'b0, 13'h0014, 2'b10, 16'h55AA, 16'h0000);
        set_row(5,  "rd_lo_byte",    OP_READ,  1'b0, 13'h0014, 2'b00, 16'h0000, 16'h12AA);
        set_row(6,  "wr_hi_byte",    OP_WRITE, 1'b0, 13'h0017, 2'b01, 16'h7700, 16'h0000);
        set_row(7,  "rd_hi_byte",    OP_READ,  1'b0, 13'h0017, 2'b00, 16'h0000, 16'h77CD);
        set_row(8,  "wr_x_p1",       OP_WRITE, 1'b0, 13'h1014, 2'b00, 16'hBEEF, 16'h0000);
        set_row(9,  "rd_x_p0_kept",  OP_READ,  1'b0, 13'h0014, 2'b00, 16'h0000, 16'h12AA);
        set_row(10, "rd_x_p1_bank1", OP_READ,  1'b1, 13'h0014, 2'b00, 16'h0000, 16'hBEEF);
        set_row(11, "rd_x_p0_bank1", OP_READ,  1'b1, 13'h1014, 2'b00, 16'h0000, 16'h12AA);
        set_row(12, "wr_y_p1",       OP_WRITE, 1'b1, 13'h0215, 2'b00, 16'h0F0F, 16'h0000);
        set_row(13, "rd_y_p1",       OP_READ,  1'b0, 13'h1215, 2'b00, 16'h0000, 16'h0F0F);
        set_row(14, "wr_code_p0",    OP_WRITE, 1'b0, 13'h0336, 2'b00, 16'hC0DE, 16'h0000);
        set_row(15, "rd_code_p0",    OP_READ,  1'b1, 13'h1336, 2'b00, 16'h0000, 16'hC0DE);
        // Scans of the hidden page
        set_row(16, "scan_13",       OP_NONE,  1'b0, 13'h0000, 2'b00, 16'd13,   16'd13);
        set_row(17, "scan_bank1",    OP_NONE,  1'b1, 13'h0000, 2'b00, 16'd7,    16'd7);
        set_row(18, "scan_disturb",  OP_NONE,  1'b0, 13'h0005, 2'b00, 16'd20,   16'd20);
        set_row(19, "scan_empty",    OP_NONE,  1'b1, 13'h0000, 2'b00, 16'd0,    16'd0);
        set_row(20, "scan_full",     OP_NONE,  1'b0, 13'h0000, 2'b00, 16'd1024, 16'd1024);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        n_checks++;
        if (exp !== act) begin
            n_mismatch++;
            $display("Mismatch %s: expected %0h, actual %0h", what, exp, act);
        end
    endtask

    // Page is bank xor addr[13] and the address gives entry and word
    function automatic void model_write(input logic bk, input logic [13:1] a,
                                        input logic [1:0] be_n, input logic [15:0] d);
        logic pg;
        pg = bk ^ a[13];
        if (!be_n[0]) model[pg][a[12:3]][a[2:1]][7:0] = d[7:0];
        if (!be_n[1]) model[pg][a[12:3]][a[2:1]][15:8] = d[15:8];
    endfunction

    function automatic logic [15:0] model_read(input logic bk, input logic [13:1] a);
        return model[bk ^ a[13]][a[12:3]][a[2:1]];
    endfunction

    // One CPU access
    // lat counts falling edges from the cs release to ok
    task automatic cpu_access(input logic bk, input logic write, input logic [13:1] a,
                              input logic [1:0] be_n, input logic [15:0] wd,
                              output logic [15:0] rd, output int lat);
        int n;
        @(posedge clk_cpu);
        cs    <= 1'b1;
        rnw   <= !write;
        obank <= bk;
        addr  <= a;
        dsn   <= be_n;
        din   <= wd;
        @(posedge clk_cpu);
        cs  <= 1'b0;
        n   = 0;
        lat = -1;
        while (lat < 0 && n < 6) begin
            @(negedge clk_cpu);
            n++;
            if (ok) lat = n;
        end
        rd = dout;
        if (lat < 0) begin
            n_other++;
            $display("Error: no ok from the DUT after a CPU access to %h", a);
        end
    endtask

    task automatic write_word(input logic bk, input logic [13:1] a, input logic [15:0] d);
        logic [15:0] rd;
        int          lat;
        cpu_access(bk, 1'b1, a, 2'b00, d, rd, lat);
        model_write(bk, a, 2'b00, d);
        check_value("table load ok latency", 1, lat);
    endtask

    // Random entries written through addr[13]
    // Marker at index n unless the page is full
    task automatic load_table(input logic bk, input int n);
        logic [15:0]          wd;
        logic [OBJ_IDX_W-1:0] ix;
        for (int e = 0; e < n; e++) begin
            ix = OBJ_IDX_W'(e);
            for (int k = 0; k < 4; k++) begin
                wd = 16'($urandom);
                if (k == 3 && wd[15:8] == END_MARK) wd[15:8] = 8'h00;
                write_word(bk, {1'b1, ix, 2'(k)}, wd);
            end
        end
        if (n < OBJ_MAX) write_word(bk, {1'b1, OBJ_IDX_W'(n), 2'd3}, {END_MARK, 8'($urandom)});
    endtask

    task automatic run_frame(input string nm, input logic bk, input int n_load,
                             input int inj_at, input int n_exp);
        logic                 pg;
        logic                 done;
        logic                 injected;
        logic [OBJ_IDX_W-1:0] ix;
        int                   cnt;
        int                   cyc;
        int                   last;
        load_table(bk, n_load);
        pg = ~bk;
        @(posedge clk_cpu);
        frame <= 1'b1;
        obank <= bk;
        @(posedge clk_cpu);
        frame    <= 1'b0;
        cnt      = 0;
        cyc      = 0;
        last     = 0;
        done     = 1'b0;
        injected = 1'b0;
        while (!done && cyc < OBJ_MAX * 3 + 16) begin
            @(negedge clk_cpu);
            cyc++;
            if (spr_valid) begin
                check_value($sformatf("%s rec %0d gap", nm, cnt), 3, cyc - last);
                last = cyc;
                ix   = OBJ_IDX_W'(cnt);
                check_value($sformatf("%s rec %0d x", nm, cnt),
                            32'(model[pg][ix][2'd0]), 32'(spr_x));
                check_value($sformatf("%s rec %0d y", nm, cnt),
                            32'(model[pg][ix][2'd1]), 32'(spr_y));
                check_value($sformatf("%s rec %0d code", nm, cnt),
                            32'(model[pg][ix][2'd2]), 32'(spr_code));
                check_value($sformatf("%s rec %0d attr", nm, cnt),
                            32'(model[pg][ix][2'd3]), 32'(spr_attr));
                cnt++;
            end
            if (scan_done) begin
                done = 1'b1;
                check_value({nm, " record count"}, n_exp, cnt);
                // Marker slot takes the place of a record
                if (n_load < OBJ_MAX) begin
                    check_value({nm, " scan_done gap"}, 3, cyc - last);
                end
            end
            // Second frame and bank flip land mid-scan
            if (frame) begin
                @(posedge clk_cpu);
                frame <= 1'b0;
            end else if (inj_at > 0 && !injected && cnt == inj_at) begin
                @(posedge clk_cpu);
                frame    <= 1'b1;
                obank    <= ~obank;
                injected = 1'b1;
            end
        end
        if (!done) begin
            n_other++;
            $display("Error: %s never raised scan_done", nm);
        end
        repeat (4) begin
            @(negedge clk_cpu);
            if (spr_valid || scan_done) begin
                n_other++;
                $display("Error: %s saw a strobe after scan_done", nm);
            end
        end
    endtask

    // Watchdog budget is dominated by the table loads
    initial begin
        int limit;
        limit = N_ROWS * 4 + N_FRAMES * (OBJ_MAX * 3 + OBJ_MAX * 4 * 4 + 64) + 500;
        repeat (limit) @(posedge clk_cpu);
        $display("Error: watchdog expired after %0d cycles, run stopped", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [15:0] rd;
        int          lat;
        arst_n     = 1'b0;
        cs         = 1'b0;
        rnw        = 1'b1;
        dsn        = 2'b11;
        addr       = '0;
        din        = '0;
        obank      = 1'b0;
        frame      = 1'b0;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        seed_ret   = $urandom(32'h111b92e2);
        build_table();
        repeat (5) @(posedge clk_cpu);
        arst_n <= 1'b1;
        for (int i = 0; i < N_ROWS; i++) begin
            if (row_op[i] == OP_WRITE) begin
                cpu_access(row_bank[i], 1'b1, row_addr[i], row_dsn[i], row_data[i], rd, lat);
                model_write(row_bank[i], row_addr[i], row_dsn[i], row_data[i]);
                check_value({row_name[i], " ok latency"}, 1, lat);
            end else if (row_op[i] == OP_READ) begin
                cpu_access(row_bank[i], 1'b0, row_addr[i], row_dsn[i], row_data[i], rd, lat);
                check_value({row_name[i], " ok latency"}, 2, lat);
                check_value(row_name[i], 32'(row_exp[i]), 32'(rd));
                check_value({row_name[i], " model"},
                            32'(model_read(row_bank[i], row_addr[i])), 32'(rd));
            end else begin
                run_frame(row_name[i], row_bank[i], int'(row_data[i]), int'(row_addr[i]),
                          int'(row_exp[i]));
            end
        end
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/obj_pkg.sv
rtl/obj_dual_ram.sv
rtl/obj_cpu_port.sv
rtl/obj_ram.sv
rtl/obj_scanner.sv
rtl/obj_sys.sv
bench/obj_sys_sva.sv
bench/obj_sys_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the object table testbench with Verilator
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module obj_sys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vobj_sys_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
